// File: rtl/cpu_pkg.sv
/*
 * shared types and constants of the 6502 subset model
 * opcode and timing state enums, bus direction levels, fixed addresses
 */
`default_nettype none

package cpu_pkg;

    // supported opcodes, any other byte runs as NOP
    typedef enum logic [7:0]
    {
        OP_BRK     = 8'h00,
        OP_STA_ABS = 8'h8D,
        OP_LDA_IMM = 8'hA9,
        OP_LDA_ABS = 8'hAD,
        OP_NOP     = 8'hEA
    } opcode_e;

    // timing counter states
    typedef enum logic [2:0]
    {
        T0, T1, T2, T3, T4, T5, T6, T7
    } tcu_e;

    localparam logic RW_READ  = 1'b1;
    localparam logic RW_WRITE = 1'b0;

    // page left on ADH by the stack cycles
    localparam logic [7:0] STACK_PAGE = 8'h01;

    // reset vector, low byte here and high byte one above
    localparam logic [15:0] VECTOR_LO = 16'hFFFC;

endpackage

`default_nettype wire

// File: rtl/ctrl_if.sv
/*
 * control lines from the decode ROM to the datapath
 * rom side drives, dp side samples; all lines are levels
 */
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if;

    logic rw;

    // bus transfers
    logic dl_db;
    logic dl_adh;
    logic pcl_adl;
    logic pch_adh;
    logic pcl_pcl;
    logic pch_pch;
    logic adl_pcl;
    logic adh_pch;
    logic i_pc;
    logic ac_db;
    logic sb_ac;
    logic sb_db;
    logic s_adl;
    logic sb_s;
    logic add_adl;
    logic add_sb;
    logic adl_abl;
    logic adh_abh;
    logic zero_adl0;
    logic zero_adl1;
    logic zero_adh1_7;

    // adder inputs and sum
    logic db_add;
    logic adl_add;
    logic sb_add;
    logic zero_add;
    logic sums;

    modport rom
    (
        output rw, dl_db, dl_adh, pcl_adl, pch_adh, pcl_pcl, pch_pch, adl_pcl, adh_pch,
        output i_pc, ac_db, sb_ac, sb_db, s_adl, sb_s, add_adl, add_sb, adl_abl, adh_abh,
        output zero_adl0, zero_adl1, zero_adh1_7, db_add, adl_add, sb_add, zero_add, sums
    );

    // rw leaves the chip at the top level, the datapath never needs it
    modport dp
    (
        input dl_db, dl_adh, pcl_adl, pch_adh, pcl_pcl, pch_pch, adl_pcl, adh_pch,
        input i_pc, ac_db, sb_ac, sb_db, s_adl, sb_s, add_adl, add_sb, adl_abl, adh_abh,
        input zero_adl0, zero_adl1, zero_adh1_7, db_add, adl_add, sb_add, zero_add, sums
    );

endinterface

`default_nettype wire

// File: rtl/decode_rom.sv
/*
 * decode ROM, combinational (IR, TCU) to bus transfer controls
 * also picks the next TCU so each opcode sets its own length
 */
`timescale 1ns/1ps
`default_nettype none

module decode_rom
(
    input  wire cpu_pkg::opcode_e i_ir,
    input  wire cpu_pkg::tcu_e    i_tcu,
    output cpu_pkg::tcu_e         o_tcu_next,
    ctrl_if.rom                   o_ctrl
);

    always_comb
    begin
        // count up unless the opcode ends here
        o_tcu_next = cpu_pkg::tcu_e'(i_tcu + 3'd1);

        o_ctrl.rw          = cpu_pkg::RW_READ;
        o_ctrl.dl_db       = 1'b0;
        o_ctrl.dl_adh      = 1'b0;
        o_ctrl.pcl_adl     = 1'b0;
        o_ctrl.pch_adh     = 1'b0;
        o_ctrl.pcl_pcl     = 1'b0;
        o_ctrl.pch_pch     = 1'b0;
        o_ctrl.adl_pcl     = 1'b0;
        o_ctrl.adh_pch     = 1'b0;
        o_ctrl.i_pc        = 1'b0;
        o_ctrl.ac_db       = 1'b0;
        o_ctrl.sb_ac       = 1'b0;
        o_ctrl.sb_db       = 1'b0;
        o_ctrl.s_adl       = 1'b0;
        o_ctrl.sb_s        = 1'b0;
        o_ctrl.add_adl     = 1'b0;
        o_ctrl.add_sb      = 1'b0;
        o_ctrl.adl_abl     = 1'b0;
        o_ctrl.adh_abh     = 1'b0;
        o_ctrl.zero_adl0   = 1'b0;
        o_ctrl.zero_adl1   = 1'b0;
        o_ctrl.zero_adh1_7 = 1'b0;
        o_ctrl.db_add      = 1'b0;
        o_ctrl.adl_add     = 1'b0;
        o_ctrl.sb_add      = 1'b0;
        o_ctrl.zero_add    = 1'b0;
        o_ctrl.sums        = 1'b0;

        case (i_tcu)
            cpu_pkg::T0:
            begin
                // PC already points past the opcode, put it out and step on
                o_ctrl.pcl_adl = 1'b1;
                o_ctrl.pch_adh = 1'b1;
                o_ctrl.adl_abl = 1'b1;
                o_ctrl.adh_abh = 1'b1;
                o_ctrl.pcl_pcl = 1'b1;
                o_ctrl.pch_pch = 1'b1;
                o_ctrl.i_pc    = 1'b1;
            end
            cpu_pkg::T1:
            begin
                case (i_ir)
                    cpu_pkg::OP_BRK:
                    begin
                        // stack address 01:S, start S - 1 in the adder
                        o_ctrl.s_adl       = 1'b1;
                        o_ctrl.adl_abl     = 1'b1;
                        o_ctrl.zero_adh1_7 = 1'b1;
                        o_ctrl.adh_abh     = 1'b1;
                        o_ctrl.adl_add     = 1'b1;
                        o_ctrl.sb_add      = 1'b1;
                        o_ctrl.sums        = 1'b1;
                    end
                    cpu_pkg::OP_LDA_IMM:
                    begin
                        o_ctrl.pcl_adl = 1'b1;
                        o_ctrl.pch_adh = 1'b1;
                        o_ctrl.adl_abl = 1'b1;
                        o_ctrl.adh_abh = 1'b1;
                        o_ctrl.pcl_pcl = 1'b1;
                        o_ctrl.pch_pch = 1'b1;
                        o_ctrl.i_pc    = 1'b1;
                        // operand straight into AC
                        o_ctrl.dl_db   = 1'b1;
                        o_ctrl.sb_db   = 1'b1;
                        o_ctrl.sb_ac   = 1'b1;
                        o_tcu_next     = cpu_pkg::T0;
                    end
                    cpu_pkg::OP_LDA_ABS, cpu_pkg::OP_STA_ABS:
                    begin
                        o_ctrl.pcl_adl  = 1'b1;
                        o_ctrl.pch_adh  = 1'b1;
                        o_ctrl.adl_abl  = 1'b1;
                        o_ctrl.adh_abh  = 1'b1;
                        o_ctrl.pcl_pcl  = 1'b1;
                        o_ctrl.pch_pch  = 1'b1;
                        o_ctrl.i_pc     = 1'b1;
                        // low address byte parks in ADD
                        o_ctrl.dl_db    = 1'b1;
                        o_ctrl.db_add   = 1'b1;
                        o_ctrl.zero_add = 1'b1;
                        o_ctrl.sums     = 1'b1;
                    end
                    default:
                    begin
                        // NOP and unknown bytes, address still holds the next opcode
                        o_tcu_next = cpu_pkg::T0;
                    end
                endcase
            end
            cpu_pkg::T2:
            begin
                case (i_ir)
                    cpu_pkg::OP_BRK:
                    begin
                        o_ctrl.add_adl     = 1'b1;
                        o_ctrl.adl_abl     = 1'b1;
                        o_ctrl.zero_adh1_7 = 1'b1;
                        o_ctrl.adh_abh     = 1'b1;
                        // SB floats high, so the sum is another decrement
                        o_ctrl.adl_add     = 1'b1;
                        o_ctrl.sb_add      = 1'b1;
                        o_ctrl.sums        = 1'b1;
                    end
                    cpu_pkg::OP_LDA_ABS, cpu_pkg::OP_STA_ABS:
                    begin
                        // effective address: ADD low, incoming byte high
                        o_ctrl.add_adl = 1'b1;
                        o_ctrl.adl_abl = 1'b1;
                        o_ctrl.dl_adh  = 1'b1;
                        o_ctrl.adh_abh = 1'b1;
                    end
                    default:
                    begin
                        o_tcu_next = cpu_pkg::T0;
                    end
                endcase
            end
            cpu_pkg::T3:
            begin
                case (i_ir)
                    cpu_pkg::OP_BRK:
                    begin
                        o_ctrl.add_adl     = 1'b1;
                        o_ctrl.adl_abl     = 1'b1;
                        o_ctrl.zero_adh1_7 = 1'b1;
                        o_ctrl.adh_abh     = 1'b1;
                        o_ctrl.add_sb      = 1'b1;
                        o_ctrl.sb_s        = 1'b1;
                    end
                    cpu_pkg::OP_LDA_ABS, cpu_pkg::OP_STA_ABS:
                    begin
                        o_ctrl.pcl_adl = 1'b1;
                        o_ctrl.pch_adh = 1'b1;
                        o_ctrl.adl_abl = 1'b1;
                        o_ctrl.adh_abh = 1'b1;
                        o_ctrl.pcl_pcl = 1'b1;
                        o_ctrl.pch_pch = 1'b1;
                        o_ctrl.i_pc    = 1'b1;
                        if (i_ir == cpu_pkg::OP_LDA_ABS)
                        begin
                            o_ctrl.dl_db = 1'b1;
                            o_ctrl.sb_db = 1'b1;
                            o_ctrl.sb_ac = 1'b1;
                        end
                        else
                        begin
                            o_ctrl.ac_db = 1'b1;
                            o_ctrl.rw    = cpu_pkg::RW_WRITE;
                        end
                        o_tcu_next = cpu_pkg::T0;
                    end
                    default:
                    begin
                        o_tcu_next = cpu_pkg::T0;
                    end
                endcase
            end
            cpu_pkg::T4:
            begin
                // vector low byte at FFFC, precharged FF with bits 0 and 1 pulled
                o_ctrl.adl_abl   = 1'b1;
                o_ctrl.zero_adl0 = 1'b1;
                o_ctrl.zero_adl1 = 1'b1;
                o_ctrl.adh_abh   = 1'b1;
            end
            cpu_pkg::T5:
            begin
                o_ctrl.adl_abl   = 1'b1;
                o_ctrl.zero_adl1 = 1'b1;
                o_ctrl.adh_abh   = 1'b1;
                // hold the vector low byte
                o_ctrl.dl_db     = 1'b1;
                o_ctrl.db_add    = 1'b1;
                o_ctrl.zero_add  = 1'b1;
                o_ctrl.sums      = 1'b1;
            end
            cpu_pkg::T6:
            begin
                // jump through the vector, PC keeps its one-ahead lead
                o_ctrl.add_adl = 1'b1;
                o_ctrl.dl_adh  = 1'b1;
                o_ctrl.adl_abl = 1'b1;
                o_ctrl.adh_abh = 1'b1;
                o_ctrl.adl_pcl = 1'b1;
                o_ctrl.adh_pch = 1'b1;
                o_ctrl.i_pc    = 1'b1;
                o_tcu_next     = cpu_pkg::T0;
            end
            default:
            begin
                o_tcu_next = cpu_pkg::T0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/timing_gen.sv
/*
 * timing generator, holds TCU and the instruction register
 * reset parks in BRK T1 so the vector sequence runs on release
 */
`timescale 1ns/1ps
`default_nettype none

module timing_gen
(
    input  wire                i_clk,
    input  wire                i_arst_n,
    input  wire [7:0]          i_data,
    input  wire cpu_pkg::tcu_e i_tcu_next,
    output cpu_pkg::tcu_e      o_tcu,
    output cpu_pkg::opcode_e   o_ir,
    output logic               o_sync
);

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            o_tcu <= cpu_pkg::T1;
            o_ir  <= cpu_pkg::OP_BRK;
        end
        else
        begin
            o_tcu <= i_tcu_next;
            // opcode byte is on the data pins during T0
            if (o_tcu == cpu_pkg::T0)
            begin
                o_ir <= cpu_pkg::opcode_e'(i_data);
            end
        end
    end

    assign o_sync = (o_tcu == cpu_pkg::T0);

endmodule

`default_nettype wire

// File: rtl/datapath.sv
/*
 * datapath: precharged DB, SB, ADL and ADH buses
 * PC with incrementer, AC, S, adder with ADD hold register
 * registered address bus
 */
`timescale 1ns/1ps
`default_nettype none

module datapath
(
    input  wire         i_clk,
    input  wire         i_arst_n,
    input  wire  [7:0]  i_data,
    ctrl_if.dp          i_ctrl,
    output logic [15:0] o_addr,
    output logic [7:0]  o_data
);

    logic [7:0]  pcl;
    logic [7:0]  pch;
    logic [7:0]  ac;
    logic [7:0]  s;
    logic [7:0]  add;
    logic [7:0]  abl;
    logic [7:0]  abh;

    logic [7:0]  dl;
    logic [7:0]  db_src;
    logic [7:0]  sb_src;
    logic [7:0]  db_bus;
    logic [7:0]  sb_bus;
    logic [7:0]  adl_raw;
    logic [7:0]  adl_bus;
    logic [7:0]  adh_raw;
    logic [7:0]  adh_bus;

    logic [7:0]  add_a;
    logic [7:0]  add_b;
    logic [7:0]  sum;
    logic [7:0]  pcl_sel;
    logic [7:0]  pch_sel;
    logic [15:0] pc_inc;

    // data latch is transparent with a single clock
    assign dl = i_data;

    // each bus is the AND of its enabled sources, idle sources pull nothing
    assign db_src = (i_ctrl.dl_db ? dl : 8'hFF) & (i_ctrl.ac_db ? ac : 8'hFF);
    assign sb_src = i_ctrl.add_sb ? add : 8'hFF;

    // sb_db shorts DB and SB together
    assign db_bus = i_ctrl.sb_db ? (db_src & sb_src) : db_src;
    assign sb_bus = i_ctrl.sb_db ? (db_src & sb_src) : sb_src;

    assign adl_raw = (i_ctrl.pcl_adl ? pcl : 8'hFF)
                   & (i_ctrl.s_adl ? s : 8'hFF)
                   & (i_ctrl.add_adl ? add : 8'hFF);
    assign adl_bus = adl_raw & {6'h3F, ~i_ctrl.zero_adl1, ~i_ctrl.zero_adl0};

    assign adh_raw = (i_ctrl.pch_adh ? pch : 8'hFF) & (i_ctrl.dl_adh ? dl : 8'hFF);
    // bits 7..1 forced low leaves the stack page
    assign adh_bus = i_ctrl.zero_adh1_7 ? (adh_raw & cpu_pkg::STACK_PAGE) : adh_raw;

    // adder, sum only
    assign add_a = (i_ctrl.sb_add && !i_ctrl.zero_add) ? sb_bus : 8'h00;
    assign add_b = i_ctrl.db_add ? db_bus : (i_ctrl.adl_add ? adl_bus : 8'h00);
    assign sum   = add_a + add_b;

    // PC source select then increment, carry runs into PCH
    assign pcl_sel = i_ctrl.adl_pcl ? adl_bus : pcl;
    assign pch_sel = i_ctrl.adh_pch ? adh_bus : pch;
    assign pc_inc  = {pch_sel, pcl_sel} + {15'd0, i_ctrl.i_pc};

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            pcl <= 8'h00;
            pch <= 8'h00;
        end
        else
        begin
            if (i_ctrl.pcl_pcl || i_ctrl.adl_pcl)
            begin
                pcl <= pc_inc[7:0];
            end
            if (i_ctrl.pch_pch || i_ctrl.adh_pch)
            begin
                pch <= pc_inc[15:8];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            ac  <= 8'h00;
            s   <= 8'h00;
            add <= 8'h00;
        end
        else
        begin
            if (i_ctrl.sb_ac)
            begin
                ac <= sb_bus;
            end
            if (i_ctrl.sb_s)
            begin
                s <= sb_bus;
            end
            // ADD holds unless a new sum is strobed
            if (i_ctrl.sums)
            begin
                add <= sum;
            end
        end
    end

    // address register, loaded halves keep their value otherwise
    always_ff @(posedge i_clk or negedge i_arst_n)
    begin
        if (!i_arst_n)
        begin
            abl <= 8'h00;
            abh <= 8'h00;
        end
        else
        begin
            if (i_ctrl.adl_abl)
            begin
                abl <= adl_bus;
            end
            if (i_ctrl.adh_abh)
            begin
                abh <= adh_bus;
            end
        end
    end

    assign o_addr = {abh, abl};
    assign o_data = db_bus;

endmodule

`default_nettype wire

// File: rtl/cpu_top.sv
/*
 * CPU top level
 * timing generator, decode ROM and datapath joined by one control bundle
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_top
(
    input  wire         i_clk,
    input  wire         i_arst_n,
    input  wire  [7:0]  i_data,
    output logic [15:0] o_addr,
    output logic [7:0]  o_data,
    output logic        o_rw,
    output logic        o_sync
);

    cpu_pkg::tcu_e    tcu;
    cpu_pkg::tcu_e    tcu_next;
    cpu_pkg::opcode_e ir;

    ctrl_if ctrl_bus ();

    timing_gen timing_gen_i
    (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_data     (i_data),
        .i_tcu_next (tcu_next),
        .o_tcu      (tcu),
        .o_ir       (ir),
        .o_sync     (o_sync)
    );

    decode_rom decode_rom_i
    (
        .i_ir       (ir),
        .i_tcu      (tcu),
        .o_tcu_next (tcu_next),
        .o_ctrl     (ctrl_bus.rom)
    );

    datapath datapath_i
    (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_data   (i_data),
        .i_ctrl   (ctrl_bus.dp),
        .o_addr   (o_addr),
        .o_data   (o_data)
    );

    assign o_rw = ctrl_bus.rw;

endmodule

`default_nettype wire

// File: bench/cpu_assertions.sv
/*
 * concurrent checks on the CPU bus pins
 * write versus fetch, single-cycle sync, read level during reset
 * bound into the CPU top level
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_assertions
(
    input wire i_clk,
    input wire i_arst_n,
    input wire i_rw,
    input wire i_sync
);

    int fail_count = 0;

    // a write cycle is never an opcode fetch
    write_not_fetch: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_rw == cpu_pkg::RW_WRITE) |-> !i_sync)
    else
    begin
        fail_count = fail_count + 1;
        $error("write cycle marked as opcode fetch");
    end

    // every instruction takes at least two cycles
    sync_single: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_sync |=> !i_sync)
    else
    begin
        fail_count = fail_count + 1;
        $error("sync high in two cycles in a row");
    end

    rw_read_in_reset: assert property (@(posedge i_clk)
        !i_arst_n |-> (i_rw == cpu_pkg::RW_READ))
    else
    begin
        fail_count = fail_count + 1;
        $error("bus not at read while in reset");
    end

endmodule

bind cpu_top cpu_assertions cpu_assertions_i
(
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_rw     (o_rw),
    .i_sync   (o_sync)
);

`default_nettype wire

// File: bench/cpu_tb.sv
/*
 * testbench for the 6502 subset CPU
 * clock, reset, 64 KB memory, random program, reference model
 * per-instruction comparison and watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    localparam int          CLK_PERIOD    = 8;
    localparam int          RESET_CYCLES  = 3;
    localparam int          VECTOR_CYCLES = 7;
    localparam int          NUM_INSTR     = 200;
    localparam int          MAX_CYCLES    = 16;
    localparam logic [15:0] PROG_BASE     = 16'h8000;
    localparam int          TIMEOUT_NS    = NUM_INSTR * 4 * CLK_PERIOD * 2
                                          + (RESET_CYCLES + VECTOR_CYCLES) * CLK_PERIOD;

    logic        i_clk = 1'b0;
    logic        i_arst_n;
    logic [7:0]  i_data = 8'h00;
    logic [15:0] o_addr;
    logic [7:0]  o_data;
    logic        o_rw;
    logic        o_sync;

    logic [7:0]  mem [0:65535];
    logic [7:0]  ref_mem [0:65535];
    logic [15:0] prog_ptr;
    int          mismatch_count;
    int          problem_count;

    cpu_top cpu_top_i
    (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_data   (i_data),
        .o_addr   (o_addr),
        .o_data   (o_data),
        .o_rw     (o_rw),
        .o_sync   (o_sync)
    );

    initial
    begin
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // drive read data for the current address mid-cycle
    always @(negedge i_clk)
    begin
        i_data = mem[o_addr];
    end

    always @(posedge i_clk)
    begin
        if (i_arst_n && o_rw == cpu_pkg::RW_WRITE)
        begin
            mem[o_addr] = o_data;
        end
    end

    task automatic report_mismatch
    (
        input string       name,
        input logic [15:0] expected,
        input logic [15:0] actual
    );
        mismatch_count++;
        $display("CHECK FAILED %s: expected %h, got %h at %0t", name, expected, actual, $time);
    endtask

    task automatic report_problem(input string what);
        problem_count++;
        $display("%s at %0t", what, $time);
    endtask

    function automatic logic [7:0] fill_byte(input logic [15:0] a);
        return a[15:8] ^ {a[3:0], a[7:4]} ^ 8'hA5;
    endfunction

    task automatic emit_byte(input logic [7:0] b);
        mem[prog_ptr] = b;
        prog_ptr = prog_ptr + 16'd1;
    endtask

    // opcode plus operand bytes with absolute operands in page 02
    task automatic emit_instr(input logic [7:0] op);
        emit_byte(op);
        if (op == cpu_pkg::OP_LDA_IMM)
        begin
            emit_byte(8'($urandom));
        end
        else if (op == cpu_pkg::OP_LDA_ABS || op == cpu_pkg::OP_STA_ABS)
        begin
            emit_byte(8'($urandom));
            emit_byte(8'h02);
        end
    endtask

    task automatic load_memory;
        int kind;
        for (int a = 0; a < 65536; a++)
        begin
            mem[16'(a)] = fill_byte(16'(a));
        end
        for (int a = 'h200; a < 'h300; a++)
        begin
            mem[16'(a)] = 8'($urandom);
        end
        mem[cpu_pkg::VECTOR_LO]         = PROG_BASE[7:0];
        mem[cpu_pkg::VECTOR_LO + 16'd1] = PROG_BASE[15:8];
        prog_ptr = PROG_BASE;
        // immediate store, memory copy, then an unsupported byte
        emit_instr(cpu_pkg::OP_LDA_IMM);
        emit_instr(cpu_pkg::OP_STA_ABS);
        emit_instr(cpu_pkg::OP_LDA_ABS);
        emit_instr(cpu_pkg::OP_STA_ABS);
        emit_instr(8'hFF);
        for (int n = 5; n < NUM_INSTR; n++)
        begin
            kind = int'($urandom_range(0, 8));
            case (kind)
                0, 1: emit_instr(cpu_pkg::OP_NOP);
                2, 3: emit_instr(cpu_pkg::OP_LDA_IMM);
                4, 5: emit_instr(cpu_pkg::OP_LDA_ABS);
                6, 7: emit_instr(cpu_pkg::OP_STA_ABS);
                default: emit_instr(8'hFF);
            endcase
        end
        ref_mem = mem;
    endtask

    // one instruction of the reference machine where unknown opcodes act as NOP
    function automatic logic [15:0] ref_step
    (
        input  logic [15:0] pc,
        inout  logic [7:0]  acc,
        output int          cycles,
        output logic        is_write,
        output logic [15:0] waddr,
        output logic [7:0]  wdata
    );
        logic [7:0]  op;
        logic [15:0] operand;
        logic [15:0] next_pc;
        op       = ref_mem[pc];
        operand  = {ref_mem[pc + 16'd2], ref_mem[pc + 16'd1]};
        is_write = 1'b0;
        waddr    = 16'h0000;
        wdata    = 8'h00;
        case (op)
            cpu_pkg::OP_LDA_IMM:
            begin
                acc     = ref_mem[pc + 16'd1];
                next_pc = pc + 16'd2;
                cycles  = 2;
            end
            cpu_pkg::OP_LDA_ABS:
            begin
                acc     = ref_mem[operand];
                next_pc = pc + 16'd3;
                cycles  = 4;
            end
            cpu_pkg::OP_STA_ABS:
            begin
                is_write = 1'b1;
                waddr    = operand;
                wdata    = acc;
                next_pc  = pc + 16'd3;
                cycles   = 4;
            end
            default:
            begin
                next_pc = pc + 16'd1;
                cycles  = 2;
            end
        endcase
        return next_pc;
    endfunction

    // address seen in each cycle after reset release
    function automatic logic [15:0] reset_addr(input int step);
        case (step)
            1: return 16'h0000;
            2: return 16'h0100;
            3: return 16'h01FF;
            4: return 16'h01FE;
            5: return cpu_pkg::VECTOR_LO;
            6: return cpu_pkg::VECTOR_LO + 16'd1;
            default: return PROG_BASE;
        endcase
    endfunction

    task automatic check_reset;
        logic exp_sync;
        for (int k = 1; k <= VECTOR_CYCLES; k++)
        begin
            @(posedge i_clk);
            exp_sync = (k == VECTOR_CYCLES);
            if (o_addr !== reset_addr(k))
            begin
                report_mismatch("o_addr", reset_addr(k), o_addr);
            end
            if (o_sync !== exp_sync)
            begin
                report_mismatch("o_sync", 16'(exp_sync), 16'(o_sync));
            end
            if (o_rw !== cpu_pkg::RW_READ)
            begin
                report_mismatch("o_rw", 16'(cpu_pkg::RW_READ), 16'(o_rw));
            end
        end
    endtask

    task automatic run_program;
        logic [15:0] pc;
        logic [15:0] next_pc;
        logic [7:0]  acc;
        int          exp_cycles;
        logic        exp_write;
        logic [15:0] exp_waddr;
        logic [7:0]  exp_wdata;
        int          cycles;
        logic        done;
        pc  = PROG_BASE;
        acc = 8'h00;
        for (int n = 0; n < NUM_INSTR; n++)
        begin
            next_pc = ref_step(pc, acc, exp_cycles, exp_write, exp_waddr, exp_wdata);
            cycles  = 0;
            done    = 1'b0;
            while (!done)
            begin
                @(posedge i_clk);
                cycles++;
                // STA writes in T3
                if (exp_write && cycles == 3)
                begin
                    if (o_rw !== cpu_pkg::RW_WRITE)
                    begin
                        report_mismatch("o_rw", 16'(cpu_pkg::RW_WRITE), 16'(o_rw));
                    end
                    if (o_addr !== exp_waddr)
                    begin
                        report_mismatch("o_addr", exp_waddr, o_addr);
                    end
                    if (o_data !== exp_wdata)
                    begin
                        report_mismatch("o_data", 16'(exp_wdata), 16'(o_data));
                    end
                end
                else if (o_rw !== cpu_pkg::RW_READ)
                begin
                    report_mismatch("o_rw", 16'(cpu_pkg::RW_READ), 16'(o_rw));
                end
                done = (o_sync === 1'b1) || (cycles >= MAX_CYCLES);
            end
            if (o_sync !== 1'b1)
            begin
                report_problem($sformatf("no opcode fetch within %0d cycles after %h",
                                         MAX_CYCLES, pc));
                return;
            end
            if (cycles != exp_cycles)
            begin
                report_problem($sformatf("instruction at %h took %0d cycles instead of %0d",
                                         pc, cycles, exp_cycles));
            end
            if (o_addr !== next_pc)
            begin
                report_mismatch("o_addr", next_pc, o_addr);
            end
            if (exp_write)
            begin
                ref_mem[exp_waddr] = exp_wdata;
            end
            pc = next_pc;
        end
    endtask

    initial
    begin
        int total;
        i_arst_n       = 1'b0;
        mismatch_count = 0;
        problem_count  = 0;
        void'($urandom(84));
        load_memory();
        repeat (RESET_CYCLES) @(negedge i_clk);
        i_arst_n = 1'b1;
        check_reset();
        run_program();
        total = mismatch_count + problem_count + cpu_top_i.cpu_assertions_i.fail_count;
        $display("errors: %0d value mismatches, %0d timing errors, %0d assertion failures",
                 mismatch_count, problem_count, cpu_top_i.cpu_assertions_i.fail_count);
        if (total == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // worst case of four cycles per instruction and twice that as margin
    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout: the program did not finish within %0d ns", TIMEOUT_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
rtl/cpu_pkg.sv
rtl/ctrl_if.sv
rtl/decode_rom.sv
rtl/timing_gen.sv
rtl/datapath.sv
rtl/cpu_top.sv
bench/cpu_assertions.sv
bench/cpu_tb.sv

// File: Makefile
# Verilator lint and simulation of the CPU model

TOP := cpu_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f files.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f files.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@grep -q "^TESTBENCH PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
